/* verilog/neoPalettePkg.sv */
`default_nettype none

package neoPalettePkg;

	// Region hit by the current CPU address
	typedef enum logic [1:0] {
		regNone,
		regPalette,
		regSysLatch
	} busRegion;

	// Palette entries per bank, as address bits
	localparam int palIndexWidth = 12;

	// One palette word
	// Bit 15 dark, 14..12 low RGB bits, 11..0 high RGB nibbles
	localparam int colorWordWidth = 16;

	// Per channel DAC level
	localparam int dacWidth = 7;

	// System latch bit positions
	localparam logic [2:0] latchShadow = 3'd0;
	// Cleared bit means bank 1
	localparam logic [2:0] latchPalBank = 3'd7;

endpackage

`default_nettype wire

/* verilog/cpuInterface.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuInterface import neoPalettePkg::*; #(
	parameter int dtackWait = 1
) (
	input wire clk6MB,
	input wire arstN,
	// 68000 bus, word address
	input wire [23:1] addr,
	input wire [colorWordWidth-1:0] wrData,
	input wire asN,
	input wire udsN,
	input wire ldsN,
	input wire rwN,
	output logic [colorWordWidth-1:0] rdData,
	output logic dtackN,
	// Palette RAM CPU port
	output logic [1:0] palWe,
	output logic [palIndexWidth:0] palAddr,
	output logic [colorWordWidth-1:0] palWrData,
	input wire [colorWordWidth-1:0] palRdData,
	// Latch outputs to the video side
	output logic palBank,
	output logic shadow
);

	// Counter reaches dtackWait+1, the edge DTACK goes low
	localparam int cntWidth = $clog2(dtackWait + 2);
	localparam logic [cntWidth-1:0] lastCnt = cntWidth'(dtackWait + 1);

	// Latch window 0x3A0000-0x3A001F
	localparam logic [23:0] sysLatchBase = 24'h3A0000;

	busRegion region;
	logic [cntWidth-1:0] waitCnt;
	logic ackNow;
	logic latchWr;
	logic [7:0] sysLatch;

	// Address decode
	always_comb begin
		region = regNone;
		if (addr[23:20] == 4'h4) begin
			// Whole 0x4xxxxx window, mirrors included
			region = regPalette;
		end else if (addr[23:5] == sysLatchBase[23:5]) begin
			region = regSysLatch;
		end
	end

	// Edge where DTACK is first asserted
	// Only one per bus cycle since dtackN is then low
	assign ackNow = !asN && (region != regNone) && dtackN && (waitCnt == lastCnt);

	// Byte enables, upper on bit 1
	assign palWe = (ackNow && region == regPalette && !rwN) ? ~{udsN, ldsN} : 2'b00;

	// Latch sits on the odd byte lane
	assign latchWr = ackNow && region == regSysLatch && !rwN && !ldsN;

	// Wait counter and DTACK
	always_ff @(posedge clk6MB or negedge arstN) begin
		if (!arstN) begin
			waitCnt <= '0;
			dtackN <= 1'b1;
		end else if (asN) begin
			// Bus cycle over
			waitCnt <= '0;
			dtackN <= 1'b1;
		end else if (ackNow) begin
			dtackN <= 1'b0;
		end else if (dtackN && waitCnt != lastCnt) begin
			// Saturates, unmapped accesses just stall here
			waitCnt <= waitCnt + 1'b1;
		end
	end

	// System latch
	// A3..A1 pick the bit, A4 is the value
	always_ff @(posedge clk6MB or negedge arstN) begin
		if (!arstN) begin
			sysLatch <= '0;
		end else if (latchWr) begin
			sysLatch[addr[3:1]] <= addr[4];
		end
	end

	assign shadow = sysLatch[latchShadow];
	assign palBank = ~sysLatch[latchPalBank];

	// Bank on top of the word index
	assign palAddr = {palBank, addr[palIndexWidth:1]};
	assign palWrData = wrData;

	// Read data only while DTACK is held, otherwise bus idles at zero
	assign rdData = (!dtackN && rwN && region == regPalette) ? palRdData : '0;

	// DTACK drops once AS has been high for a cycle
	assert property (@(posedge clk6MB) disable iff (!arstN)
		asN && $past(asN) |-> dtackN)
		else $error("DTACK held low after AS release");

	// Palette strobe stays inside the palette window
	assert property (@(posedge clk6MB) disable iff (!arstN)
		(|palWe) |-> region == regPalette)
		else $error("Palette write outside palette region");

	// No second strobe before AS goes high
	assert property (@(posedge clk6MB) disable iff (!arstN)
		(|palWe) |=> (palWe == 2'b00) until asN)
		else $error("Palette write fired twice in one bus cycle");

endmodule

`default_nettype wire

/* verilog/paletteRam.sv */
`timescale 1ns/1ps
`default_nettype none

module paletteRam import neoPalettePkg::*; (
	input wire clk6MB,
	input wire arstN,
	// CPU port
	input wire [1:0] palWe,
	input wire [palIndexWidth:0] palAddr,
	input wire [colorWordWidth-1:0] palWrData,
	output logic [colorWordWidth-1:0] palRdData,
	// Video port
	input wire [palIndexWidth-1:0] pixIndex,
	input wire bnkN,
	input wire palBank,
	input wire shadow,
	output logic [colorWordWidth-1:0] pixColor,
	output logic pixBnkN,
	output logic pixShadow
);

	// Two banks back to back, bank is the top address bit
	localparam int depth = 2 ** (palIndexWidth + 1);
	localparam int byteWidth = colorWordWidth / 2;

	logic [colorWordWidth-1:0] palMem [depth];
	logic [palIndexWidth:0] cpuAddrQ;
	logic [colorWordWidth-1:0] vidWord;

	// CPU byte writes
	always_ff @(posedge clk6MB) begin
		if (palWe[1]) begin
			palMem[palAddr][colorWordWidth-1 -: byteWidth] <=
				palWrData[colorWordWidth-1 -: byteWidth];
		end
		if (palWe[0]) begin
			palMem[palAddr][byteWidth-1:0] <= palWrData[byteWidth-1:0];
		end
	end

	// CPU read address, data valid the cycle after AS falls
	always_ff @(posedge clk6MB) begin
		cpuAddrQ <= palAddr;
	end

	assign palRdData = palMem[cpuAddrQ];

	// Video read stage
	// Same edge as a CPU write gives the old word
	always_ff @(posedge clk6MB) begin
		vidWord <= palMem[{palBank, pixIndex}];
	end

	assign pixColor = vidWord;

	// Blank and shadow follow the pixel through the read stage
	always_ff @(posedge clk6MB or negedge arstN) begin
		if (!arstN) begin
			pixBnkN <= 1'b0;
			pixShadow <= 1'b0;
		end else begin
			pixBnkN <= bnkN;
			pixShadow <= shadow;
		end
	end

	// Write enables must be clean after reset
	assert property (@(posedge clk6MB) disable iff (!arstN)
		!$isunknown(palWe))
		else $error("Palette write enable unknown");

endmodule

`default_nettype wire

/* verilog/colorOutput.sv */
`timescale 1ns/1ps
`default_nettype none

module colorOutput import neoPalettePkg::*; (
	input wire clk6MB,
	input wire arstN,
	// Word from the palette read stage
	input wire [colorWordWidth-1:0] pixColor,
	input wire pixBnkN,
	input wire pixShadow,
	// DAC levels
	output logic [dacWidth-1:0] videoR,
	output logic [dacWidth-1:0] videoG,
	output logic [dacWidth-1:0] videoB
);

	logic [4:0] red5;
	logic [4:0] green5;
	logic [4:0] blue5;
	logic darkBit;
	logic [dacWidth-1:0] nextR;
	logic [dacWidth-1:0] nextG;
	logic [dacWidth-1:0] nextB;

	// Binary weighted ladder
	// Dark and shadow are the two smallest steps, both active high
	function automatic logic [dacWidth-1:0] dacLevel(
		input logic [4:0] level5,
		input logic dark,
		input logic shade
	);
		return {level5, ~dark, ~shade};
	endfunction

	// High nibble then the channel's low bit
	assign red5 = {pixColor[11:8], pixColor[14]};
	assign green5 = {pixColor[7:4], pixColor[13]};
	assign blue5 = {pixColor[3:0], pixColor[12]};
	assign darkBit = pixColor[15];

	// Blanking wins over everything
	always_comb begin
		if (pixBnkN) begin
			nextR = dacLevel(red5, darkBit, pixShadow);
			nextG = dacLevel(green5, darkBit, pixShadow);
			nextB = dacLevel(blue5, darkBit, pixShadow);
		end else begin
			nextR = '0;
			nextG = '0;
			nextB = '0;
		end
	end

	// Output register, second pipe stage
	always_ff @(posedge clk6MB or negedge arstN) begin
		if (!arstN) begin
			videoR <= '0;
			videoG <= '0;
			videoB <= '0;
		end else begin
			videoR <= nextR;
			videoG <= nextG;
			videoB <= nextB;
		end
	end

	// Blanked pixel must come out black
	assert property (@(posedge clk6MB) disable iff (!arstN)
		!pixBnkN |=> (videoR == '0 && videoG == '0 && videoB == '0))
		else $error("Blanked pixel not black");

endmodule

`default_nettype wire

/* verilog/neoPalette.sv */
`timescale 1ns/1ps
`default_nettype none

module neoPalette import neoPalettePkg::*; #(
	// Extra wait states before DTACK, 0 to 3
	parameter int dtackWait = 1
) (
	input wire clk6MB,
	input wire arstN,
	// 68000 side
	input wire [23:1] addr,
	input wire [colorWordWidth-1:0] wrData,
	input wire asN,
	input wire udsN,
	input wire ldsN,
	input wire rwN,
	output logic [colorWordWidth-1:0] rdData,
	output logic dtackN,
	// Line buffer side
	input wire [palIndexWidth-1:0] pixIndex,
	input wire bnkN,
	// DAC side
	output logic [dacWidth-1:0] videoR,
	output logic [dacWidth-1:0] videoG,
	output logic [dacWidth-1:0] videoB
);

	// CPU to palette RAM
	logic [1:0] palWe;
	logic [palIndexWidth:0] palAddr;
	logic [colorWordWidth-1:0] palWrData;
	logic [colorWordWidth-1:0] palRdData;
	// Latch state
	logic palBank;
	logic shadow;
	// Palette RAM to output stage
	logic [colorWordWidth-1:0] pixColor;
	logic pixBnkN;
	logic pixShadow;

	cpuInterface #(
		.dtackWait(dtackWait)
	) uCpuInterface (
		.clk6MB(clk6MB),
		.arstN(arstN),
		.addr(addr),
		.wrData(wrData),
		.asN(asN),
		.udsN(udsN),
		.ldsN(ldsN),
		.rwN(rwN),
		.rdData(rdData),
		.dtackN(dtackN),
		.palWe(palWe),
		.palAddr(palAddr),
		.palWrData(palWrData),
		.palRdData(palRdData),
		.palBank(palBank),
		.shadow(shadow)
	);

	// Read stage, first video pipe stage
	paletteRam uPaletteRam (
		.clk6MB(clk6MB),
		.arstN(arstN),
		.palWe(palWe),
		.palAddr(palAddr),
		.palWrData(palWrData),
		.palRdData(palRdData),
		.pixIndex(pixIndex),
		.bnkN(bnkN),
		.palBank(palBank),
		.shadow(shadow),
		.pixColor(pixColor),
		.pixBnkN(pixBnkN),
		.pixShadow(pixShadow)
	);

	colorOutput uColorOutput (
		.clk6MB(clk6MB),
		.arstN(arstN),
		.pixColor(pixColor),
		.pixBnkN(pixBnkN),
		.pixShadow(pixShadow),
		.videoR(videoR),
		.videoG(videoG),
		.videoB(videoB)
	);

endmodule

`default_nettype wire

/* testbench/neoPaletteTb.sv */
`timescale 1ns/1ps
`default_nettype none

module neoPaletteTb;

	localparam int dtackWait = 1;
	localparam int resetCycles = 16;
	localparam int numFill = 32;
	localparam int numByteWr = 48;
	localparam int numPix = 200;
	// Longest bus cycle including the gap after it
	localparam int busCycles = dtackWait + 8;
	localparam int testCycles = resetCycles + (2 * numFill + 2 * numByteWr + 64) * busCycles
		+ 6 * numPix;
	// Give up on DTACK after this many edges
	localparam int dtackLimit = dtackWait + 8;

	logic clk6MB;
	logic arstN;
	logic [23:1] addr;
	logic [15:0] wrData;
	logic asN;
	logic udsN;
	logic ldsN;
	logic rwN;
	logic [15:0] rdData;
	logic dtackN;
	logic [11:0] pixIndex;
	logic bnkN;
	logic [6:0] videoR;
	logic [6:0] videoG;
	logic [6:0] videoB;

	// Reference palette, both banks, plus the latch
	bit [15:0] palModel [8192];
	logic [7:0] latchModel;
	// Indices known to hold a written word
	logic [11:0] bankIdx1[$];
	logic [11:0] bankIdx0[$];
	logic [15:0] lfsr;
	// Checker state
	logic [20:0] expPipe0;
	logic [20:0] expPipe1;
	logic checkRd;
	logic [15:0] expRd;
	logic unmappedBusy;
	int valueErrors;
	int timeoutErrors;

	neoPalette #(
		.dtackWait(dtackWait)
	) dut (
		.clk6MB(clk6MB),
		.arstN(arstN),
		.addr(addr),
		.wrData(wrData),
		.asN(asN),
		.udsN(udsN),
		.ldsN(ldsN),
		.rwN(rwN),
		.rdData(rdData),
		.dtackN(dtackN),
		.pixIndex(pixIndex),
		.bnkN(bnkN),
		.videoR(videoR),
		.videoG(videoG),
		.videoB(videoB)
	);

	initial begin
		clk6MB = 1'b0;
		forever begin
			#5 clk6MB = ~clk6MB;
		end
	end

	// Color rule, R G B packed high to low
	function automatic logic [20:0] rgbRule(input logic [15:0] word, input logic shade,
		input logic blank);
		logic [6:0] r;
		logic [6:0] g;
		logic [6:0] b;
		r = {word[11:8], word[14], ~word[15], ~shade};
		g = {word[7:4], word[13], ~word[15], ~shade};
		b = {word[3:0], word[12], ~word[15], ~shade};
		if (blank) begin
			return '0;
		end
		return {r, g, b};
	endfunction

	// Galois form, taps 16 14 13 11
	function automatic logic [15:0] lfsrStep(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	// One step per bit taken
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsrStep(lfsr);
			value = {value[14:0], lfsr[0]};
		end
		return value;
	endfunction

	function automatic logic [23:0] palByteAddr(input logic [11:0] idx);
		return {11'h200, idx, 1'b0};
	endfunction

	// Expected color follows the pixel through two stages
	always @(posedge clk6MB) begin
		expPipe0 <= rgbRule(palModel[{~latchModel[7], pixIndex}], latchModel[0], !bnkN);
		expPipe1 <= expPipe0;
	end

	// Idle outputs right after reset
	assert property (@(posedge clk6MB) $rose(arstN) |-> dtackN && {videoR, videoG, videoB} == '0)
		else begin
			valueErrors++;
			$display("Fail %0t ns: DTACK or RGB not idle after reset", $time);
		end

	assert property (@(posedge clk6MB) disable iff (!arstN)
		{videoR, videoG, videoB} == expPipe1)
		else begin
			valueErrors++;
			$display("Fail %0t ns: RGB %h %h %h, expected %h", $time, $sampled(videoR),
				$sampled(videoG), $sampled(videoB), $sampled(expPipe1));
		end

	assert property (@(posedge clk6MB) disable iff (!arstN) !dtackN && checkRd |-> rdData == expRd)
		else begin
			valueErrors++;
			$display("Fail %0t ns: read data %h, expected %h", $time, $sampled(rdData),
				$sampled(expRd));
		end

	// Bus idles at zero
	assert property (@(posedge clk6MB) disable iff (!arstN) dtackN |-> rdData == '0)
		else begin
			valueErrors++;
			$display("Fail %0t ns: read data %h without DTACK", $time, $sampled(rdData));
		end

	assert property (@(posedge clk6MB) disable iff (!arstN) unmappedBusy |-> dtackN)
		else begin
			valueErrors++;
			$display("Fail %0t ns: DTACK for an unmapped address", $time);
		end

	// One 68000 cycle, returns whether DTACK came
	task automatic runBusCycle(input logic [23:0] byteAddr, input logic [15:0] data,
		input logic write, input logic upper, input logic lower, input logic doCheck,
		input logic [15:0] expData, output logic acked);
		int waited;
		@(posedge clk6MB);
		addr <= byteAddr[23:1];
		wrData <= data;
		rwN <= !write;
		udsN <= !upper;
		ldsN <= !lower;
		asN <= 1'b0;
		checkRd <= doCheck;
		expRd <= expData;
		waited = 0;
		do begin
			@(posedge clk6MB);
			waited++;
		end while (dtackN !== 1'b0 && waited < dtackLimit);
		acked = (dtackN === 1'b0);
		// AS seen one edge after the drive, DTACK seen one edge after it falls
		assert (!acked || waited == dtackWait + 3)
			else begin
				valueErrors++;
				$display("Fail %0t ns: DTACK after %0d edges, expected %0d", $time, waited,
					dtackWait + 3);
			end
		asN <= 1'b1;
		udsN <= 1'b1;
		ldsN <= 1'b1;
		rwN <= 1'b1;
		checkRd <= 1'b0;
	endtask

	task automatic busAccess(input logic [23:0] byteAddr, input logic [15:0] data,
		input logic write, input logic upper, input logic lower, input logic doCheck,
		input logic [15:0] expData);
		logic acked;
		runBusCycle(byteAddr, data, write, upper, lower, doCheck, expData, acked);
		if (!acked) begin
			timeoutErrors++;
			$display("Timeout at %0t ns: no DTACK for address %h", $time, byteAddr);
		end
	endtask

	// Model follows the DUT once DTACK is seen, video is blank then
	task automatic palWrite(input logic [11:0] idx, input logic [15:0] data,
		input logic upper, input logic lower);
		busAccess(palByteAddr(idx), data, 1'b1, upper, lower, 1'b0, '0);
		if (upper) begin
			palModel[{~latchModel[7], idx}][15:8] = data[15:8];
		end
		if (lower) begin
			palModel[{~latchModel[7], idx}][7:0] = data[7:0];
		end
	endtask

	task automatic palRead(input logic [11:0] idx);
		busAccess(palByteAddr(idx), '0, 1'b0, 1'b1, 1'b1, 1'b1,
			palModel[{~latchModel[7], idx}]);
	endtask

	// A3..A1 select, A4 value, odd byte only
	task automatic latchWrite(input logic [23:0] byteAddr, input logic upper, input logic lower);
		busAccess(byteAddr, '0, 1'b1, upper, lower, 1'b0, '0);
		if (lower) begin
			latchModel[byteAddr[3:1]] = byteAddr[4];
		end
	endtask

	// Random written indices of the active bank
	task automatic streamPixels(input int count, input logic blank);
		logic [15:0] pick;
		for (int i = 0; i < count; i++) begin
			@(posedge clk6MB);
			pick = randBits(8);
			if (latchModel[7]) begin
				pixIndex <= bankIdx0[pick % bankIdx0.size()];
			end else begin
				pixIndex <= bankIdx1[pick % bankIdx1.size()];
			end
			bnkN <= !blank;
		end
		@(posedge clk6MB);
		bnkN <= 1'b0;
	endtask

	initial begin
		logic [15:0] word;
		logic [15:0] pick;
		logic [11:0] idx;
		logic acked;
		lfsr = 16'd40242;
		valueErrors = 0;
		timeoutErrors = 0;
		arstN = 1'b0;
		addr = '0;
		wrData = '0;
		asN = 1'b1;
		udsN = 1'b1;
		ldsN = 1'b1;
		rwN = 1'b1;
		pixIndex = '0;
		bnkN = 1'b0;
		latchModel = '0;
		checkRd = 1'b0;
		expRd = '0;
		unmappedBusy = 1'b0;
		expPipe0 = '0;
		expPipe1 = '0;
		repeat (resetCycles) @(posedge clk6MB);
		arstN <= 1'b1;
		repeat (2) @(posedge clk6MB);
		// Word 0 goes to bank 1 with the latch clear
		palWrite(12'd0, 16'h7BDE, 1'b1, 1'b1);
		bankIdx1.push_back(12'd0);
		palRead(12'd0);
		for (int i = 1; i < numFill; i++) begin
			pick = randBits(12);
			idx = pick[11:0];
			word = randBits(16);
			palWrite(idx, word, 1'b1, 1'b1);
			bankIdx1.push_back(idx);
		end
		// Strobe code 1 upper only, 2 lower only, else full word
		for (int i = 0; i < numByteWr; i++) begin
			pick = randBits(8);
			idx = bankIdx1[pick % bankIdx1.size()];
			word = randBits(16);
			pick = randBits(2);
			palWrite(idx, word, pick != 2, pick != 1);
			palRead(idx);
		end
		streamPixels(numPix, 1'b0);
		// Shadow on, then an upper byte write that must be ignored
		latchWrite(24'h3A0011, 1'b0, 1'b1);
		streamPixels(numPix / 2, 1'b0);
		latchWrite(24'h3A0001, 1'b1, 1'b0);
		streamPixels(numPix / 2, 1'b0);
		latchWrite(24'h3A0001, 1'b0, 1'b1);
		streamPixels(numPix / 2, 1'b0);
		// Bank 0 reuses bank 1 indices
		latchWrite(24'h3A001F, 1'b0, 1'b1);
		for (int i = 0; i < 16; i++) begin
			word = randBits(16);
			palWrite(bankIdx1[i], word, 1'b1, 1'b1);
			bankIdx0.push_back(bankIdx1[i]);
		end
		for (int i = 0; i < 16; i++) begin
			palRead(bankIdx0[i]);
		end
		streamPixels(numPix / 2, 1'b0);
		latchWrite(24'h3A000F, 1'b0, 1'b1);
		for (int i = 0; i < 16; i++) begin
			palRead(bankIdx1[i]);
		end
		streamPixels(numPix / 2, 1'b0);
		streamPixels(numPix / 4, 1'b1);
		// Unmapped read, DTACK must stay high
		repeat (2) @(posedge clk6MB);
		unmappedBusy <= 1'b1;
		runBusCycle(24'h200000, '0, 1'b0, 1'b1, 1'b1, 1'b0, '0, acked);
		unmappedBusy <= 1'b0;
		repeat (4) @(posedge clk6MB);
		$display("Checks done: %0d value errors, %0d DTACK timeouts", valueErrors, timeoutErrors);
		if (valueErrors == 0 && timeoutErrors == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	// Twice the clock period per planned cycle, plus slack
	initial begin
		#(testCycles * 20 + 2000);
		$display("Watchdog expired before the tests finished");
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* neoPalette.f */
verilog/neoPalettePkg.sv
verilog/cpuInterface.sv
verilog/paletteRam.sv
verilog/colorOutput.sv
verilog/neoPalette.sv
testbench/neoPaletteTb.sv

/* Makefile */
TOP = neoPaletteTb
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f neoPalette.f \
		--top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Simulation PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
